// File: sources.f
+incdir+.
rvc_pkg.sv
rvc_quadrant0_expander.sv
rvc_quadrant1_expander.sv
rvc_quadrant2_expander.sv
rvc_expander_top.sv
tb_rvc_expander.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_rvc_expander
FILELIST  = sources.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qF "$(PASS_MSG)"; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)

// File: tb_rvc_vectors.svh
`ifndef TB_RVC_VECTORS_SVH
`define TB_RVC_VECTORS_SVH

    // each row holds the test name, the 16-bit compressed input and the expected base word
    task automatic load_vectors();
        // quadrant 0
        add_vector("c_addi4spn_x8_4", 16'h0040, 32'h0041_0413);
        add_vector("c_addi4spn_x15_1020", 16'h1FFC, 32'h3FC1_0793);
        add_vector("c_lw_x9_4_x10", 16'h4144, 32'h0045_2483);
        add_vector("c_lw_x15_124_x15", 16'h5FFC, 32'h07C7_A783);
        add_vector("c_sw_x8_0_x9", 16'hC080, 32'h0084_A023);
        add_vector("c_sw_x15_124_x8", 16'hDC7C, 32'h06F4_2E23);
        add_vector("q0_all_zero", 16'h0000, 32'h0000_0013);
        add_vector("q0_fld_slot", 16'h2000, 32'h0000_0013);
        add_vector("q0_reserved_100", 16'h8000, 32'h0000_0013);
        // quadrant 1
        add_vector("c_addi_x5_neg3", 16'h12F5, 32'hFFD2_8293);
        add_vector("c_addi_x1_31", 16'h00FD, 32'h01F0_8093);
        add_vector("c_jal_neg2", 16'h3FFD, 32'hFFFF_F0EF);
        add_vector("c_jal_164", 16'h2055, 32'h0A40_00EF);
        add_vector("c_j_neg2048", 16'hB001, 32'h801F_F06F);
        add_vector("c_j_1872", 16'hAF81, 32'h7500_006F);
        add_vector("c_li_x10_neg32", 16'h5501, 32'hFE00_0513);
        add_vector("c_addi16sp_neg64", 16'h7139, 32'hFC01_0113);
        add_vector("c_addi16sp_496", 16'h617D, 32'h1F01_0113);
        add_vector("c_lui_x3_neg1", 16'h71FD, 32'hFFFF_F1B7);
        add_vector("c_lui_x15_1", 16'h6785, 32'h0000_17B7);
        add_vector("c_srli_x8_4", 16'h8011, 32'h0044_5413);
        add_vector("c_srai_x9_31", 16'h84FD, 32'h41F4_D493);
        add_vector("c_andi_x10_neg1", 16'h997D, 32'hFFF5_7513);
        add_vector("c_sub_x8_x9", 16'h8C05, 32'h4094_0433);
        add_vector("c_xor_x11_x12", 16'h8DB1, 32'h00C5_C5B3);
        add_vector("c_or_x14_x15", 16'h8F5D, 32'h00F7_6733);
        add_vector("c_and_x13_x8", 16'h8EE1, 32'h0086_F6B3);
        add_vector("c_beqz_x8_neg4", 16'hDC75, 32'hFE04_0EE3);
        add_vector("c_beqz_x9_40", 16'hC485, 32'h0204_8463);
        add_vector("c_bnez_x15_254", 16'hEFFD, 32'h0E07_9F63);
        add_vector("q1_srli_shamt5", 16'h9005, 32'h0000_0013);
        // quadrant 2
        add_vector("c_slli_x7_3", 16'h038E, 32'h0033_9393);
        add_vector("c_lwsp_x1_252", 16'h50FE, 32'h0FC1_2083);
        add_vector("c_lwsp_x10_20", 16'h4552, 32'h0141_2503);
        add_vector("c_swsp_x15_132", 16'hC33E, 32'h08F1_2223);
        add_vector("c_jr_x1", 16'h8082, 32'h0000_8067);
        add_vector("c_mv_x10_x11", 16'h852E, 32'h00B0_0533);
        add_vector("c_ebreak", 16'h9002, 32'h0010_0073);
        add_vector("c_jalr_x5", 16'h9282, 32'h0002_80E7);
        add_vector("c_add_x31_x30", 16'h9FFA, 32'h01EF_8FB3);
        add_vector("q2_fldsp_slot", 16'h2082, 32'h0000_0013);
        // low bits 11 belong to a full-width instruction
        add_vector("base_addi_low", 16'h0093, 32'h0000_0013);
        add_vector("base_all_ones", 16'hFFFF, 32'h0000_0013);
    endtask

`endif

// File: tb_rvc_expander.sv
`timescale 1ns/1ps

module tb_rvc_expander;

    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 3;
    localparam int WATCHDOG_MARGIN = 20;
    localparam int unsigned LCG_SEED = 10649;
    // addi x0, x0, 0
    localparam logic [31:0] NOP_WORD = 32'h0000_0013;

    logic        clk_i;
    logic        rst_n_i;
    logic        valid_i;
    logic [15:0] inst_i;
    logic        valid_o;
    logic [31:0] inst_o;

    // stimulus table, one entry per row
    string       name_q[$];
    logic [15:0] input_q[$];
    logic [31:0] expect_q[$];
    logic        vectors_loaded;

    // row currently on inst_i, -1 while idle
    int          drive_idx;
    int unsigned lcg_state;

    int          checks_done;
    int          value_errors;
    int          strobe_errors;

    rvc_expander_top rvc_expander_top_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (valid_i),
        .inst_i  (inst_i),
        .valid_o (valid_o),
        .inst_o  (inst_o)
    );

    task automatic add_vector(input string name, input logic [15:0] inst,
                              input logic [31:0] expected);
        name_q.push_back(name);
        input_q.push_back(inst);
        expect_q.push_back(expected);
    endtask

    `include "tb_rvc_vectors.svh"

    function automatic int unsigned lcg_next(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    initial begin
        clk_i = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_i = ~clk_i;
        end
    end

    // driver
    initial begin
        rst_n_i   <= 1'b0;
        valid_i   <= 1'b0;
        inst_i    <= 16'h0000;
        drive_idx <= -1;
        vectors_loaded = 1'b0;
        lcg_state = LCG_SEED;
        load_vectors();
        vectors_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;
        foreach (input_q[i]) begin
            @(posedge clk_i);
            valid_i   <= 1'b1;
            inst_i    <= input_q[i];
            drive_idx <= i;
            lcg_state = lcg_next(lcg_state);
            // sometimes an idle cycle with junk on inst_i
            if (lcg_state[16]) begin
                @(posedge clk_i);
                valid_i   <= 1'b0;
                inst_i    <= lcg_state[31:16];
                drive_idx <= -1;
            end
        end
        @(posedge clk_i);
        valid_i   <= 1'b0;
        drive_idx <= -1;
        // drain the last result plus an idle cycle
        repeat (3) @(posedge clk_i);
        $display("summary: %0d checks, %0d value errors, %0d strobe errors",
                 checks_done, value_errors, strobe_errors);
        if (value_errors + strobe_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // checker, outputs are stable at the falling edge
    initial begin
        int          pend_idx;
        logic        pend_valid;
        logic [31:0] held_word;
        logic [31:0] want_word;
        string       test_name;
        checks_done = 0;
        value_errors = 0;
        strobe_errors = 0;
        pend_idx = -1;
        pend_valid = 1'b0;
        held_word = NOP_WORD;
        @(posedge clk_i);
        forever begin
            @(negedge clk_i);
            if (pend_valid) begin
                want_word = expect_q[pend_idx];
                test_name = name_q[pend_idx];
            end else if (!rst_n_i) begin
                want_word = held_word;
                test_name = "reset";
            end else begin
                want_word = held_word;
                test_name = "idle";
            end
            checks_done++;
            assert (valid_o === pend_valid) else begin
                $display("ERR %s: valid_o expected %b, actual %b",
                         test_name, pend_valid, valid_o);
                strobe_errors++;
            end
            assert (inst_o === want_word) else begin
                $display("ERR %s: expected %h, actual %h", test_name, want_word, inst_o);
                value_errors++;
            end
            held_word = want_word;
            // inputs seen now show up after the next rising edge
            pend_idx = drive_idx;
            pend_valid = (drive_idx >= 0);
        end
    end

    initial begin
        int limit_ns;
        wait (vectors_loaded);
        limit_ns = (input_q.size() * 3 + WATCHDOG_MARGIN) * CLK_PERIOD;
        #(limit_ns);
        $display("watchdog timeout: the run did not finish within %0d ns", limit_ns);
        $display("Test failures found");
        $finish;
    end

endmodule

// File: rvc_expander_top.sv
`timescale 1ns/1ps

module rvc_expander_top
    import rvc_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    valid_i,
    input  inst16_t inst_i,
    output logic    valid_o,
    output inst32_t inst_o
);

    inst32_t q0_inst;
    inst32_t q1_inst;
    inst32_t q2_inst;
    inst32_t sel_inst;

    // every quadrant decodes the same halfword in parallel
    rvc_quadrant0_expander rvc_quadrant0_expander_i (
        .inst_i (inst_i),
        .inst_o (q0_inst)
    );

    rvc_quadrant1_expander rvc_quadrant1_expander_i (
        .inst_i (inst_i),
        .inst_o (q1_inst)
    );

    rvc_quadrant2_expander rvc_quadrant2_expander_i (
        .inst_i (inst_i),
        .inst_o (q2_inst)
    );

    // pick by the low two bits
    always_comb begin
        case (inst_i[1:0])
            QUADRANT_C0:   sel_inst = q0_inst;
            QUADRANT_C1:   sel_inst = q1_inst;
            QUADRANT_C2:   sel_inst = q2_inst;
            QUADRANT_BASE: sel_inst = INST_NOP;
        endcase
    end

    // one cycle to the decode side, result holds through idle cycles
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
            inst_o  <= INST_NOP;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                inst_o <= sel_inst;
            end
        end
    end

endmodule

// File: rvc_quadrant2_expander.sv
`timescale 1ns/1ps

module rvc_quadrant2_expander
    import rvc_pkg::*;
(
    input  inst16_t inst_i,
    output inst32_t inst_o
);

    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [11:0] lwsp_imm;
    logic [11:0] swsp_imm;

    assign funct3 = inst_i[15:13];
    // rd doubles as rs1 for jr/jalr/add
    assign rd     = inst_i[11:7];
    assign rs2    = inst_i[6:2];

    // uimm[7:2] off the stack pointer
    assign lwsp_imm = {4'b0000, inst_i[3:2], inst_i[12], inst_i[6:4], 2'b00};
    assign swsp_imm = {4'b0000, inst_i[8:7], inst_i[12:9], 2'b00};

    always_comb begin
        inst_o = INST_NOP;
        case (funct3)
            3'b000: begin
                // c.slli, shamt[5] reserved on RV32
                if (!inst_i[12]) begin
                    inst_o = {7'b0000000, rs2, rd, F3_SLL, rd, OPC_OP_IMM};
                end
            end
            3'b010: begin
                // c.lwsp: lw rd, uimm(x2)
                inst_o = {lwsp_imm, REG_SP, F3_WORD, rd, OPC_LOAD};
            end
            3'b100: begin
                if (!inst_i[12]) begin
                    if (rs2 == REG_ZERO) begin
                        // c.jr: jalr x0, 0(rs1)
                        // rs1 = x0 is reserved
                        if (rd != REG_ZERO) begin
                            inst_o = {12'h000, rd, 3'b000, REG_ZERO, OPC_JALR};
                        end
                    end else begin
                        // c.mv: add rd, x0, rs2
                        inst_o = {7'b0000000, rs2, REG_ZERO, F3_ADD, rd, OPC_OP};
                    end
                end else begin
                    if (rs2 == REG_ZERO) begin
                        if (rd == REG_ZERO) begin
                            inst_o = EBREAK_WORD;
                        end else begin
                            // c.jalr: jalr x1, 0(rs1)
                            inst_o = {12'h000, rd, 3'b000, REG_RA, OPC_JALR};
                        end
                    end else begin
                        // c.add: add rd, rd, rs2
                        inst_o = {7'b0000000, rs2, rd, F3_ADD, rd, OPC_OP};
                    end
                end
            end
            3'b110: begin
                // c.swsp: sw rs2, uimm(x2)
                inst_o = {swsp_imm[11:5], rs2, REG_SP, F3_WORD, swsp_imm[4:0], OPC_STORE};
            end
            default: begin
                // fp stack forms and the RV64 slots
                inst_o = INST_NOP;
            end
        endcase
    end

endmodule

// File: rvc_quadrant1_expander.sv
`timescale 1ns/1ps

module rvc_quadrant1_expander
    import rvc_pkg::*;
(
    input  inst16_t inst_i,
    output inst32_t inst_o
);

    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [4:0]  rd_c;
    logic [4:0]  rs2_c;
    logic [4:0]  shamt;
    logic [11:0] imm6_sext;
    logic [11:0] addi16sp_imm;
    logic [19:0] lui_imm;
    logic [11:1] jmp_off;
    logic [19:0] jal_imm;
    logic [12:1] br_off;
    logic [6:0]  br_imm_hi;
    logic [4:0]  br_imm_lo;

    assign funct3 = inst_i[15:13];
    assign rd     = inst_i[11:7];
    assign rd_c   = creg_to_reg(inst_i[9:7]);
    assign rs2_c  = creg_to_reg(inst_i[4:2]);
    assign shamt  = inst_i[6:2];

    // 6-bit signed immediate for addi, li, andi
    assign imm6_sext = {{6{inst_i[12]}}, inst_i[12], inst_i[6:2]};

    // nzimm[9:4], sign taken from bit 12
    assign addi16sp_imm = {{3{inst_i[12]}}, inst_i[4:3], inst_i[5], inst_i[2], inst_i[6],
                           4'b0000};

    // nzimm[17:12] lands in the upper immediate
    assign lui_imm = {{14{inst_i[12]}}, inst_i[12], inst_i[6:2]};

    // jump offset[11:1], scattered over bits 12:2
    assign jmp_off = {inst_i[12], inst_i[8], inst_i[10:9], inst_i[6], inst_i[7], inst_i[2],
                      inst_i[11], inst_i[5:3]};

    // jal format wants imm[20|10:1|11|19:12]
    assign jal_imm = {jmp_off[11], jmp_off[10:1], jmp_off[11], {8{jmp_off[11]}}};

    // branch offset[8:1], sign extended up to bit 12
    assign br_off = {{5{inst_i[12]}}, inst_i[6:5], inst_i[2], inst_i[11:10], inst_i[4:3]};

    // B-type split around the register fields
    assign br_imm_hi = {br_off[12], br_off[10:5]};
    assign br_imm_lo = {br_off[4:1], br_off[11]};

    always_comb begin
        inst_o = INST_NOP;
        case (funct3)
            3'b000: begin
                // c.addi: addi rd, rd, imm
                inst_o = {imm6_sext, rd, F3_ADD, rd, OPC_OP_IMM};
            end
            3'b001: begin
                // c.jal links through ra
                inst_o = {jal_imm, REG_RA, OPC_JAL};
            end
            3'b010: begin
                // c.li: addi rd, x0, imm
                inst_o = {imm6_sext, REG_ZERO, F3_ADD, rd, OPC_OP_IMM};
            end
            3'b011: begin
                if (rd == REG_SP) begin
                    // c.addi16sp: addi x2, x2, nzimm
                    inst_o = {addi16sp_imm, REG_SP, F3_ADD, REG_SP, OPC_OP_IMM};
                end else begin
                    // c.lui: lui rd, nzimm
                    inst_o = {lui_imm, rd, OPC_LUI};
                end
            end
            3'b100: begin
                case (inst_i[11:10])
                    2'b00: begin
                        // shamt[5] set is reserved on RV32
                        if (!inst_i[12]) begin
                            inst_o = {7'b0000000, shamt, rd_c, F3_SR, rd_c, OPC_OP_IMM};
                        end
                    end
                    2'b01: begin
                        // srai carries the alternate funct7
                        if (!inst_i[12]) begin
                            inst_o = {F7_ALT, shamt, rd_c, F3_SR, rd_c, OPC_OP_IMM};
                        end
                    end
                    2'b10: begin
                        // c.andi: andi rd', rd', imm
                        inst_o = {imm6_sext, rd_c, F3_AND, rd_c, OPC_OP_IMM};
                    end
                    default: begin
                        // register group, bit 12 set means subw/addw
                        if (!inst_i[12]) begin
                            case (inst_i[6:5])
                                2'b00: begin
                                    inst_o = {F7_ALT, rs2_c, rd_c, F3_ADD, rd_c, OPC_OP};
                                end
                                2'b01: begin
                                    inst_o = {7'b0000000, rs2_c, rd_c, F3_XOR, rd_c, OPC_OP};
                                end
                                2'b10: begin
                                    inst_o = {7'b0000000, rs2_c, rd_c, F3_OR, rd_c, OPC_OP};
                                end
                                default: begin
                                    inst_o = {7'b0000000, rs2_c, rd_c, F3_AND, rd_c, OPC_OP};
                                end
                            endcase
                        end
                    end
                endcase
            end
            3'b101: begin
                // c.j discards the link
                inst_o = {jal_imm, REG_ZERO, OPC_JAL};
            end
            3'b110: begin
                // c.beqz: beq rs1', x0, offset
                inst_o = {br_imm_hi, REG_ZERO, rd_c, F3_BEQ, br_imm_lo, OPC_BRANCH};
            end
            default: begin
                // c.bnez: bne rs1', x0, offset
                inst_o = {br_imm_hi, REG_ZERO, rd_c, F3_BNE, br_imm_lo, OPC_BRANCH};
            end
        endcase
    end

endmodule

// File: rvc_quadrant0_expander.sv
`timescale 1ns/1ps

module rvc_quadrant0_expander
    import rvc_pkg::*;
(
    input  inst16_t inst_i,
    output inst32_t inst_o
);

    logic [2:0]  funct3;
    logic [4:0]  creg_lo;
    logic [4:0]  creg_hi;
    logic [11:0] addi4spn_imm;
    logic [11:0] word_imm;

    assign funct3 = inst_i[15:13];

    // rd' for addi4spn and lw, rs2' for sw
    assign creg_lo = creg_to_reg(inst_i[4:2]);
    // rs1' base register
    assign creg_hi = creg_to_reg(inst_i[9:7]);

    // nzuimm[9:2], stack offsets are word aligned
    assign addi4spn_imm = {2'b00, inst_i[10:7], inst_i[12:11], inst_i[5], inst_i[6], 2'b00};

    // uimm[6:2] for lw/sw
    assign word_imm = {5'b00000, inst_i[5], inst_i[12:10], inst_i[6], 2'b00};

    always_comb begin
        case (funct3)
            3'b000: begin
                // all-zero nzuimm is reserved, covers the 0x0000 halfword
                if (addi4spn_imm == 12'h000) begin
                    inst_o = INST_NOP;
                end else begin
                    // c.addi4spn: addi rd', x2, nzuimm
                    inst_o = {addi4spn_imm, REG_SP, F3_ADD, creg_lo, OPC_OP_IMM};
                end
            end
            3'b010: begin
                // c.lw: lw rd', uimm(rs1')
                inst_o = {word_imm, creg_hi, F3_WORD, creg_lo, OPC_LOAD};
            end
            3'b110: begin
                // c.sw: sw rs2', uimm(rs1'), immediate split around the registers
                inst_o = {word_imm[11:5], creg_lo, creg_hi, F3_WORD, word_imm[4:0],
                          OPC_STORE};
            end
            default: begin
                // fld/fsd/flw/fsw and reserved slot
                inst_o = INST_NOP;
            end
        endcase
    end

endmodule

// File: rvc_pkg.sv
package rvc_pkg;

    // raw instruction containers
    typedef logic [15:0] inst16_t;
    typedef logic [31:0] inst32_t;

    // low two bits of a halfword
    localparam logic [1:0] QUADRANT_C0   = 2'b00;
    localparam logic [1:0] QUADRANT_C1   = 2'b01;
    localparam logic [1:0] QUADRANT_C2   = 2'b10;
    // 11 marks a full 32-bit instruction
    localparam logic [1:0] QUADRANT_BASE = 2'b11;

    // base ISA major opcodes
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // funct3 for OP / OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    // shared by srl/sra, funct7 tells them apart
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 for word load/store
    localparam logic [2:0] F3_WORD = 3'b010;

    // funct3 for branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;

    // selects sub and sra
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // fixed register numbers
    localparam logic [4:0] REG_ZERO = 5'd0;
    localparam logic [4:0] REG_RA   = 5'd1;
    localparam logic [4:0] REG_SP   = 5'd2;

    // addi x0, x0, 0
    localparam inst32_t INST_NOP = {
        12'h000,
        REG_ZERO,
        F3_ADD,
        REG_ZERO,
        OPC_OP_IMM
    };

    // system opcode with imm 1
    localparam inst32_t EBREAK_WORD = 32'h0010_0073;

    // rd'/rs1'/rs2' fields only reach x8..x15
    function automatic logic [4:0] creg_to_reg(input logic [2:0] creg);
        logic [4:0] reg_num;
        reg_num = {2'b01, creg};
        return reg_num;
    endfunction

endpackage
